/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [DATA_W-1:0]       word_t;
  typedef logic [AXI_DATA_W-1:0]   dword_t;
  typedef logic [DATA_W/8-1:0]     strb4_t;
  typedef logic [AXI_DATA_W/8-1:0] strb8_t;
  typedef logic [2:0]              axsize_t;

  // mtime words of the core-local timer
  localparam addr_t CLINT_ADDR_LO = 32'h0200_bff8;
  localparam addr_t CLINT_ADDR_HI = 32'h0200_bffc;

  localparam axsize_t SIZE_BYTE = 3'd0;
  localparam axsize_t SIZE_HALF = 3'd1;
  localparam axsize_t SIZE_WORD = 3'd2;

  // fixed single-beat AXI fields
  localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [3:0] AXI_ID_ZERO    = 4'd0;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  typedef struct packed {
    addr_t addr;
    logic  valid; // held until reply
  } ifu_req_t;

  typedef struct packed {
    addr_t  addr;
    strb4_t strb;
    logic   valid;
  } lsu_rd_req_t;

  typedef struct packed {
    addr_t  addr;
    word_t  data;
    strb4_t strb;
    logic   valid; // held until wdone
  } lsu_wr_req_t;

  typedef struct packed {
    word_t data;
    logic  valid; // one-cycle pulse
  } core_rsp_t;

  typedef struct packed {
    axsize_t size;
    dword_t  data;
    strb8_t  strb;
  } axi_wr_beat_t;

  typedef enum logic [2:0] {
    IF_ADDR,
    IF_DATA,
    LS_ADDR,
    LS_READ,
    LS_WRITE
  } arb_state_t;

endpackage

`default_nettype wire

/* hdl/bus_req_decode.sv */
`default_nettype none

module bus_req_decode (
  input  bus_pkg::lsu_rd_req_t  lsu_rd_i,
  input  bus_pkg::lsu_wr_req_t  lsu_wr_i,
  output logic                  clint_hit_o,
  output bus_pkg::axsize_t      rd_size_o,
  output bus_pkg::axi_wr_beat_t wr_beat_o
);

  bus_pkg::word_t  lane_data;
  bus_pkg::strb4_t lane_strb;

  function automatic bus_pkg::axsize_t strb_to_size(input bus_pkg::strb4_t strb);
    case (strb)
      4'h1:    return bus_pkg::SIZE_BYTE;
      4'h3:    return bus_pkg::SIZE_HALF;
      default: return bus_pkg::SIZE_WORD;
    endcase
  endfunction

  function automatic logic strb_legal(input bus_pkg::strb4_t strb);
    return (strb == 4'h1) || (strb == 4'h3) || (strb == 4'hf);
  endfunction

  // timer words are answered locally
  assign clint_hit_o = lsu_rd_i.valid &&
                       ((lsu_rd_i.addr == bus_pkg::CLINT_ADDR_LO) ||
                        (lsu_rd_i.addr == bus_pkg::CLINT_ADDR_HI));

  assign rd_size_o = strb_to_size(lsu_rd_i.strb);

  always_comb
  begin
    lane_data = lsu_wr_i.data << {lsu_wr_i.addr[1:0], 3'b000};
    lane_strb = lsu_wr_i.strb << lsu_wr_i.addr[1:0];

    wr_beat_o.size = strb_to_size(lsu_wr_i.strb);
    if (lsu_wr_i.addr[2]) // upper word of the beat
    begin
      wr_beat_o.data = {lane_data, {bus_pkg::DATA_W{1'b0}}};
      wr_beat_o.strb = {lane_strb, 4'b0000};
    end
    else
    begin
      wr_beat_o.data = {{bus_pkg::DATA_W{1'b0}}, lane_data};
      wr_beat_o.strb = {4'b0000, lane_strb};
    end
  end

  // only byte, half and word accesses come from the lsu
  always_comb
  begin
    if (lsu_rd_i.valid)
    begin
      assert (strb_legal(lsu_rd_i.strb))
        else $error("illegal lsu read strobe %h", lsu_rd_i.strb);
    end
    if (lsu_wr_i.valid)
    begin
      assert (strb_legal(lsu_wr_i.strb))
        else $error("illegal lsu write strobe %h", lsu_wr_i.strb);
    end
  end

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  bus_pkg::ifu_req_t     ifu_req_i,
  input  bus_pkg::lsu_rd_req_t  lsu_rd_i,
  input  bus_pkg::lsu_wr_req_t  lsu_wr_i,
  input  logic                  clint_hit_i,
  input  logic                  clint_rvalid_i,
  input  bus_pkg::axsize_t      rd_size_i,
  input  bus_pkg::axi_wr_beat_t wr_beat_i,
  input  logic                  arready_i,
  input  logic                  rvalid_i,
  input  logic                  awready_i,
  input  logic                  wready_i,
  input  logic                  bvalid_i,
  input  logic [1:0]            rresp_i,
  input  logic [1:0]            bresp_i,
  output bus_pkg::addr_t        araddr_o,
  output bus_pkg::axsize_t      arsize_o,
  output logic                  arvalid_o,
  output bus_pkg::addr_t        awaddr_o,
  output bus_pkg::axsize_t      awsize_o,
  output logic                  awvalid_o,
  output bus_pkg::dword_t       wdata_o,
  output bus_pkg::strb8_t       wstrb_o,
  output logic                  wvalid_o,
  output logic                  grant_lsu_o,
  output logic                  rd_addr_lane_o,
  output logic                  wdone_o
);

  bus_pkg::arb_state_t state, state_d;

  logic ls_is_wr;   // lsu grant is a store
  logic if_ar_hold; // fetch ar issued but not yet accepted
  logic aw_done;
  logic w_done;
  logic lsu_pend;
  logic ifu_side;
  logic ifu_issue;
  logic aw_hs;
  logic w_hs;

  assign lsu_pend = lsu_rd_i.valid || lsu_wr_i.valid;
  assign ifu_side = (state == bus_pkg::IF_ADDR) || (state == bus_pkg::IF_DATA);

  // lsu wins unless a fetch address is already on the bus
  assign ifu_issue = (state == bus_pkg::IF_ADDR) && ifu_req_i.valid &&
                     (if_ar_hold || !lsu_pend);

  assign arvalid_o = ifu_issue ||
                     ((state == bus_pkg::LS_ADDR) && !ls_is_wr && lsu_rd_i.valid && !clint_hit_i);
  assign araddr_o  = ifu_side ? ifu_req_i.addr : lsu_rd_i.addr;
  assign arsize_o  = ifu_side ? bus_pkg::SIZE_WORD : rd_size_i;

  assign awvalid_o = (state == bus_pkg::LS_ADDR) && ls_is_wr && !aw_done;
  assign wvalid_o  = (state == bus_pkg::LS_ADDR) && ls_is_wr && !w_done;
  assign awaddr_o  = lsu_wr_i.addr;
  assign awsize_o  = wr_beat_i.size;
  assign wdata_o   = wr_beat_i.data;
  assign wstrb_o   = wr_beat_i.strb;

  assign aw_hs = awvalid_o && awready_i;
  assign w_hs  = wvalid_o && wready_i;

  assign grant_lsu_o    = (state == bus_pkg::LS_ADDR) || (state == bus_pkg::LS_READ);
  assign rd_addr_lane_o = araddr_o[2];
  assign wdone_o        = (state == bus_pkg::LS_WRITE) && bvalid_i;

  always_comb
  begin
    state_d = state;
    case (state)
      bus_pkg::IF_ADDR:
      begin
        if (ifu_issue && arready_i)
          state_d = bus_pkg::IF_DATA;
        else if (!if_ar_hold && lsu_pend)
          state_d = bus_pkg::LS_ADDR;
      end
      bus_pkg::IF_DATA:
      begin
        if (rvalid_i)
          state_d = bus_pkg::IF_ADDR;
      end
      bus_pkg::LS_ADDR:
      begin
        if (ls_is_wr)
        begin
          if ((aw_done || aw_hs) && (w_done || w_hs))
            state_d = bus_pkg::LS_WRITE;
        end
        else if (clint_hit_i)
        begin
          if (clint_rvalid_i)
            state_d = bus_pkg::IF_ADDR;
        end
        else if (arready_i)
          state_d = bus_pkg::LS_READ;
      end
      bus_pkg::LS_READ:
      begin
        if (rvalid_i)
          state_d = bus_pkg::IF_ADDR;
      end
      bus_pkg::LS_WRITE:
      begin
        if (bvalid_i)
          state_d = bus_pkg::IF_ADDR;
      end
      default: state_d = bus_pkg::IF_ADDR;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= bus_pkg::IF_ADDR;
      ls_is_wr   <= 1'b0;
      if_ar_hold <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
    end
    else
    begin
      state      <= state_d;
      if_ar_hold <= ifu_issue && !arready_i;
      if ((state == bus_pkg::IF_ADDR) && (state_d == bus_pkg::LS_ADDR))
        ls_is_wr <= lsu_wr_i.valid; // stores first
      if (aw_hs)
        aw_done <= 1'b1;
      if (w_hs)
        w_done <= 1'b1;
      if (wdone_o)
      begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
    end
  end

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> rresp_i == bus_pkg::AXI_RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> bresp_i == bus_pkg::AXI_RESP_OKAY);

  // ar must hold until taken
  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

  // no read while a store is half done
  a_one_channel: assert property (@(posedge clk) disable iff (rst)
    arvalid_o |-> !aw_done && !w_done);

endmodule

`default_nettype wire

/* hdl/bus_resp_route.sv */
`default_nettype none

module bus_resp_route (
  input  bus_pkg::dword_t    rdata_i,
  input  logic               rvalid_i,
  input  logic               grant_lsu_i,
  input  logic               rd_addr_lane_i,
  input  logic               clint_hit_i,
  input  bus_pkg::word_t     clint_rdata_i,
  input  logic               clint_rvalid_i,
  output bus_pkg::core_rsp_t ifu_rsp_o,
  output bus_pkg::core_rsp_t lsu_rsp_o
);

  bus_pkg::word_t lane_word;

  // bit 2 of the address picks the half
  assign lane_word = rd_addr_lane_i ? rdata_i[bus_pkg::DATA_W +: bus_pkg::DATA_W]
                                    : rdata_i[0 +: bus_pkg::DATA_W];

  assign ifu_rsp_o.data  = lane_word;
  assign ifu_rsp_o.valid = rvalid_i && !grant_lsu_i;

  always_comb
  begin
    if (clint_hit_i) // timer reply bypasses the bus
    begin
      lsu_rsp_o.data  = clint_rdata_i;
      lsu_rsp_o.valid = clint_rvalid_i && grant_lsu_i;
    end
    else
    begin
      lsu_rsp_o.data  = lane_word;
      lsu_rsp_o.valid = rvalid_i && grant_lsu_i;
    end
  end

  // a bus reply never lands on a timer read
  always_comb
  begin
    assert (!(rvalid_i && grant_lsu_i && clint_hit_i))
      else $error("bus read reply during a timer read");
  end

endmodule

`default_nettype wire

/* hdl/bus_clint.sv */
`default_nettype none

module bus_clint (
  input  logic           clk,
  input  logic           rst,
  input  bus_pkg::addr_t rd_addr_i,
  input  logic           rd_en_i,
  output bus_pkg::word_t rdata_o,
  output logic           rvalid_o
);

  logic [63:0] mtime;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime    <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime    <= mtime + 64'd1;
      rvalid_o <= rd_en_i; // stays up while request held
    end
  end

  // read data sampled at the same edge as the valid
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      if (rd_addr_i == bus_pkg::CLINT_ADDR_HI)
        rdata_o <= mtime[63:32];
      else
        rdata_o <= mtime[31:0];
    end
  end

endmodule

`default_nettype wire

/* hdl/bus_top.sv */
`default_nettype none

module bus_top (
  input  logic                 clk,
  input  logic                 rst,
  input  bus_pkg::ifu_req_t    ifu_req_i,
  input  bus_pkg::lsu_rd_req_t lsu_rd_i,
  input  bus_pkg::lsu_wr_req_t lsu_wr_i,
  output bus_pkg::core_rsp_t   ifu_rsp_o,
  output bus_pkg::core_rsp_t   lsu_rsp_o,
  output logic                 wdone_o,
  // AXI4 master, read
  output bus_pkg::addr_t       araddr_o,
  output bus_pkg::axsize_t     arsize_o,
  output logic [7:0]           arlen_o,
  output logic [1:0]           arburst_o,
  output logic [3:0]           arid_o,
  output logic                 arvalid_o,
  input  logic                 arready_i,
  input  bus_pkg::dword_t      rdata_i,
  input  logic [1:0]           rresp_i,
  input  logic                 rvalid_i,
  output logic                 rready_o,
  // AXI4 master, write
  output bus_pkg::addr_t       awaddr_o,
  output bus_pkg::axsize_t     awsize_o,
  output logic [7:0]           awlen_o,
  output logic [1:0]           awburst_o,
  output logic [3:0]           awid_o,
  output logic                 awvalid_o,
  input  logic                 awready_i,
  output bus_pkg::dword_t      wdata_o,
  output bus_pkg::strb8_t      wstrb_o,
  output logic                 wlast_o,
  output logic                 wvalid_o,
  input  logic                 wready_i,
  input  logic [1:0]           bresp_i,
  input  logic                 bvalid_i,
  output logic                 bready_o
);

  logic                  clint_hit;
  logic                  clint_rvalid;
  bus_pkg::word_t        clint_rdata;
  bus_pkg::axsize_t      rd_size;
  bus_pkg::axi_wr_beat_t wr_beat;
  logic                  grant_lsu;
  logic                  rd_addr_lane;

  // single beat, INCR, id 0, no back-pressure
  assign arlen_o   = bus_pkg::AXI_LEN_SINGLE;
  assign arburst_o = bus_pkg::AXI_BURST_INCR;
  assign arid_o    = bus_pkg::AXI_ID_ZERO;
  assign awlen_o   = bus_pkg::AXI_LEN_SINGLE;
  assign awburst_o = bus_pkg::AXI_BURST_INCR;
  assign awid_o    = bus_pkg::AXI_ID_ZERO;
  assign wlast_o   = 1'b1;
  assign rready_o  = 1'b1;
  assign bready_o  = 1'b1;

  bus_req_decode decode_i (
    .lsu_rd_i    (lsu_rd_i),
    .lsu_wr_i    (lsu_wr_i),
    .clint_hit_o (clint_hit),
    .rd_size_o   (rd_size),
    .wr_beat_o   (wr_beat)
  );

  bus_arbiter arbiter_i (
    .clk            (clk),
    .rst            (rst),
    .ifu_req_i      (ifu_req_i),
    .lsu_rd_i       (lsu_rd_i),
    .lsu_wr_i       (lsu_wr_i),
    .clint_hit_i    (clint_hit),
    .clint_rvalid_i (clint_rvalid),
    .rd_size_i      (rd_size),
    .wr_beat_i      (wr_beat),
    .arready_i      (arready_i),
    .rvalid_i       (rvalid_i),
    .awready_i      (awready_i),
    .wready_i       (wready_i),
    .bvalid_i       (bvalid_i),
    .rresp_i        (rresp_i),
    .bresp_i        (bresp_i),
    .araddr_o       (araddr_o),
    .arsize_o       (arsize_o),
    .arvalid_o      (arvalid_o),
    .awaddr_o       (awaddr_o),
    .awsize_o       (awsize_o),
    .awvalid_o      (awvalid_o),
    .wdata_o        (wdata_o),
    .wstrb_o        (wstrb_o),
    .wvalid_o       (wvalid_o),
    .grant_lsu_o    (grant_lsu),
    .rd_addr_lane_o (rd_addr_lane),
    .wdone_o        (wdone_o)
  );

  bus_resp_route route_i (
    .rdata_i        (rdata_i),
    .rvalid_i       (rvalid_i),
    .grant_lsu_i    (grant_lsu),
    .rd_addr_lane_i (rd_addr_lane),
    .clint_hit_i    (clint_hit),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .ifu_rsp_o      (ifu_rsp_o),
    .lsu_rsp_o      (lsu_rsp_o)
  );

  bus_clint clint_i (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_i (lsu_rd_i.addr),
    .rd_en_i   (clint_hit),
    .rdata_o   (clint_rdata),
    .rvalid_o  (clint_rvalid)
  );

endmodule

`default_nettype wire

/* tb/axi_slave_model.sv */
`default_nettype none

module axi_slave_model (
  input  logic                  clk,
  input  logic                  rst,
  input  bus_pkg::addr_t        araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output bus_pkg::dword_t       rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  bus_pkg::addr_t        awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  bus_pkg::dword_t       wdata_i,
  input  bus_pkg::strb8_t       wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 256;

  bus_pkg::dword_t  mem [0:MEM_WORDS-1];
  logic [31:0]      lcg_state;
  logic [1:0]       ar_wait;
  logic [1:0]       r_wait;
  logic [1:0]       aw_wait;
  logic [1:0]       w_wait;
  logic [1:0]       b_wait;
  logic             r_pend;
  logic             got_aw;
  logic             got_w;
  bus_pkg::addr_t   rd_addr;
  bus_pkg::addr_t   wr_addr;
  bus_pkg::dword_t  wr_data;
  bus_pkg::strb8_t  wr_strb;
  int               wr_count; // accepted writes

  function automatic logic [1:0] next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16]; // 0 to 3 cycles
  endfunction

  function automatic bus_pkg::word_t word_fill(input bus_pkg::addr_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  initial
  begin
    lcg_state = 32'd55849;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = {word_fill(bus_pkg::addr_t'(i * 8 + 4)), word_fill(bus_pkg::addr_t'(i * 8))};
  end

  assign rresp_o = bus_pkg::AXI_RESP_OKAY;
  assign bresp_o = bus_pkg::AXI_RESP_OKAY;

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_pend    <= 1'b0;
      got_aw    <= 1'b0;
      got_w     <= 1'b0;
      wr_count  <= 0;
      ar_wait   <= next_delay();
      r_wait    <= next_delay();
      aw_wait   <= next_delay();
      w_wait    <= next_delay();
      b_wait    <= next_delay();
    end
    else
    begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;
      if (bvalid_o && bready_i)
        bvalid_o <= 1'b0;

      if (arvalid_i && arready_o)
      begin
        rd_addr <= araddr_i;
        r_pend  <= 1'b1;
        r_wait  <= next_delay();
        ar_wait <= next_delay();
      end
      else if (arvalid_i && !r_pend && !rvalid_o)
      begin
        if (ar_wait == 2'd0)
          arready_o <= 1'b1;
        else
          ar_wait <= ar_wait - 2'd1;
      end
      if (r_pend)
      begin
        if (r_wait == 2'd0)
        begin
          rdata_o  <= mem[rd_addr[10:3]];
          rvalid_o <= 1'b1;
          r_pend   <= 1'b0;
        end
        else
          r_wait <= r_wait - 2'd1;
      end

      if (awvalid_i && awready_o)
      begin
        wr_addr     <= awaddr_i;
        got_aw      <= 1'b1;
        aw_wait     <= next_delay();
      end
      else if (awvalid_i && !got_aw)
      begin
        if (aw_wait == 2'd0)
          awready_o <= 1'b1;
        else
          aw_wait <= aw_wait - 2'd1;
      end
      if (wvalid_i && wready_o)
      begin
        wr_data <= wdata_i;
        wr_strb <= wstrb_i;
        got_w   <= 1'b1;
        w_wait  <= next_delay();
      end
      else if (wvalid_i && !got_w)
      begin
        if (w_wait == 2'd0)
          wready_o <= 1'b1;
        else
          w_wait <= w_wait - 2'd1;
      end

      // both halves of the store in hand
      if (got_aw && got_w && !bvalid_o)
      begin
        if (b_wait == 2'd0)
        begin
          for (int i = 0; i < 8; i++)
            if (wr_strb[i])
              mem[wr_addr[10:3]][8*i +: 8] <= wr_data[8*i +: 8];
          bvalid_o    <= 1'b1;
          got_aw      <= 1'b0;
          got_w       <= 1'b0;
          wr_count    <= wr_count + 1;
          b_wait      <= next_delay();
        end
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_bus_top.sv */
`default_nettype none

module tb_bus_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_TESTS       = 30;
  localparam int CYCLES_PER_TEST = 40;
  localparam int MAX_CYCLES      = MAX_TESTS * CYCLES_PER_TEST;

  logic                 clk;
  logic                 rst;
  bus_pkg::ifu_req_t    ifu_req;
  bus_pkg::lsu_rd_req_t lsu_rd;
  bus_pkg::lsu_wr_req_t lsu_wr;
  bus_pkg::core_rsp_t   ifu_rsp;
  bus_pkg::core_rsp_t   lsu_rsp;
  logic                 wdone;
  bus_pkg::addr_t       araddr;
  bus_pkg::axsize_t     arsize;
  logic [7:0]           arlen;
  logic [1:0]           arburst;
  logic [3:0]           arid;
  logic                 arvalid;
  logic                 arready;
  bus_pkg::dword_t      rdata;
  logic [1:0]           rresp;
  logic                 rvalid;
  logic                 rready;
  bus_pkg::addr_t       awaddr;
  bus_pkg::axsize_t     awsize;
  logic [7:0]           awlen;
  logic [1:0]           awburst;
  logic [3:0]           awid;
  logic                 awvalid;
  logic                 awready;
  bus_pkg::dword_t      wdata;
  bus_pkg::strb8_t      wstrb;
  logic                 wlast;
  logic                 wvalid;
  logic                 wready;
  logic [1:0]           bresp;
  logic                 bvalid;
  logic                 bready;

  bus_pkg::word_t   exp_ifu_data;
  bus_pkg::word_t   exp_lsu_data;
  bus_pkg::axsize_t exp_arsize;
  bus_pkg::axsize_t exp_awsize;
  bus_pkg::addr_t   exp_awaddr;
  bus_pkg::dword_t  exp_wdata; // zero outside the strobe
  bus_pkg::strb8_t  exp_wstrb;
  bus_pkg::word_t   exp_mem [0:511];
  bus_pkg::word_t   prev_clint;
  bus_pkg::word_t   last_lsu_data;
  logic             lsu_chk;
  logic             clint_inc_chk;
  logic             clint_mode;
  logic             order_mode;
  logic             lsu_seen;
  logic [31:0]      rng_state;
  string            test_name;
  int               err_count;
  int               test_err_base;
  int               tests_run;
  int               tests_failed;
  int               cycles;

  bus_top dut_i (
    .clk (clk), .rst (rst),
    .ifu_req_i (ifu_req), .lsu_rd_i (lsu_rd), .lsu_wr_i (lsu_wr),
    .ifu_rsp_o (ifu_rsp), .lsu_rsp_o (lsu_rsp), .wdone_o (wdone),
    .araddr_o (araddr), .arsize_o (arsize), .arlen_o (arlen), .arburst_o (arburst),
    .arid_o (arid), .arvalid_o (arvalid), .arready_i (arready),
    .rdata_i (rdata), .rresp_i (rresp), .rvalid_i (rvalid), .rready_o (rready),
    .awaddr_o (awaddr), .awsize_o (awsize), .awlen_o (awlen), .awburst_o (awburst),
    .awid_o (awid), .awvalid_o (awvalid), .awready_i (awready),
    .wdata_o (wdata), .wstrb_o (wstrb), .wlast_o (wlast), .wvalid_o (wvalid),
    .wready_i (wready), .bresp_i (bresp), .bvalid_i (bvalid), .bready_o (bready)
  );

  axi_slave_model slave_i (
    .clk (clk), .rst (rst),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready)
  );

  function automatic bus_pkg::word_t word_fill(input bus_pkg::addr_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state ^ {16'h0, rng_state[31:16]};
  endfunction

  // byte count of the strobe gives the AXI size
  function automatic bus_pkg::axsize_t size_of(input bus_pkg::strb4_t s);
    case ($countones(s))
      1:       return bus_pkg::SIZE_BYTE;
      2:       return bus_pkg::SIZE_HALF;
      default: return bus_pkg::SIZE_WORD;
    endcase
  endfunction

  function automatic bus_pkg::dword_t strobe_mask(input bus_pkg::strb8_t s);
    bus_pkg::dword_t m;
    for (int i = 0; i < 8; i++)
      m[8*i +: 8] = {8{s[i]}};
    return m;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  a_ifu_data: assert property (@(posedge clk) disable iff (rst)
    ifu_rsp.valid |-> ifu_rsp.data == exp_ifu_data)
    else
    begin
      $display("Mismatch in %s: ifu data expected %h, actual %h",
               test_name, exp_ifu_data, ifu_rsp.data);
      err_count++;
    end

  a_lsu_data: assert property (@(posedge clk) disable iff (rst)
    lsu_chk && lsu_rsp.valid |-> lsu_rsp.data == exp_lsu_data)
    else
    begin
      $display("Mismatch in %s: lsu data expected %h, actual %h",
               test_name, exp_lsu_data, lsu_rsp.data);
      err_count++;
    end

  a_clint_inc: assert property (@(posedge clk) disable iff (rst)
    clint_inc_chk && lsu_rsp.valid |-> lsu_rsp.data > prev_clint)
    else
    begin
      $display("Mismatch in %s: mtime expected above %h, actual %h",
               test_name, prev_clint, lsu_rsp.data);
      err_count++;
    end

  a_clint_no_ar: assert property (@(posedge clk) disable iff (rst)
    clint_mode |-> !arvalid)
    else
    begin
      $display("%s: a timer read put a request on the AXI read channel", test_name);
      err_count++;
    end

  a_order: assert property (@(posedge clk) disable iff (rst)
    order_mode && ifu_rsp.valid |-> lsu_seen)
    else
    begin
      $display("%s: the fetch was answered before the load", test_name);
      err_count++;
    end

  a_arsize: assert property (@(posedge clk) disable iff (rst)
    arvalid |-> arsize == exp_arsize)
    else
    begin
      $display("Mismatch in %s: arsize expected %0d, actual %0d", test_name, exp_arsize, arsize);
      err_count++;
    end

  a_aw: assert property (@(posedge clk) disable iff (rst)
    awvalid |-> awaddr == exp_awaddr && awsize == exp_awsize)
    else
    begin
      $display("Mismatch in %s: aw expected %h/%0d, actual %h/%0d",
               test_name, exp_awaddr, exp_awsize, awaddr, awsize);
      err_count++;
    end

  a_wstrb: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> wstrb == exp_wstrb)
    else
    begin
      $display("Mismatch in %s: wstrb expected %h, actual %h", test_name, exp_wstrb, wstrb);
      err_count++;
    end

  a_wdata: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> (wdata & strobe_mask(wstrb)) == exp_wdata)
    else
    begin
      $display("Mismatch in %s: wdata expected %h, actual %h",
               test_name, exp_wdata, wdata & strobe_mask(wstrb));
      err_count++;
    end

  // single beat, INCR, id 0
  a_ar_fixed: assert property (@(posedge clk) disable iff (rst)
    arvalid |-> arlen == 8'd0 && arburst == 2'b01 && arid == 4'd0)
    else
    begin
      $display("Mismatch in %s: ar len/burst/id expected 0/1/0, actual %0d/%0d/%0d",
               test_name, arlen, arburst, arid);
      err_count++;
    end

  a_aw_fixed: assert property (@(posedge clk) disable iff (rst)
    awvalid |-> awlen == 8'd0 && awburst == 2'b01 && awid == 4'd0)
    else
    begin
      $display("Mismatch in %s: aw len/burst/id expected 0/1/0, actual %0d/%0d/%0d",
               test_name, awlen, awburst, awid);
      err_count++;
    end

  a_wlast: assert property (@(posedge clk) disable iff (rst)
    wvalid |-> wlast)
    else
    begin
      $display("Mismatch in %s: wlast expected 1, actual %b", test_name, wlast);
      err_count++;
    end

  a_readies: assert property (@(posedge clk) disable iff (rst)
    rready && bready)
    else
    begin
      $display("Mismatch in %s: rready/bready expected 1/1, actual %b/%b",
               test_name, rready, bready);
      err_count++;
    end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic fetch(input bus_pkg::addr_t addr);
    step();
    exp_ifu_data  = exp_mem[addr[10:2]];
    exp_arsize    = bus_pkg::SIZE_WORD;
    ifu_req.addr  = addr;
    ifu_req.valid = 1'b1;
    do
      @(negedge clk);
    while (!ifu_rsp.valid);
    step();
    ifu_req.valid = 1'b0;
  endtask

  task automatic load(input bus_pkg::addr_t addr, input bus_pkg::strb4_t strb,
                      input bus_pkg::word_t expect_data);
    step();
    exp_lsu_data = expect_data;
    exp_arsize   = size_of(strb);
    lsu_rd.addr  = addr;
    lsu_rd.strb  = strb;
    lsu_rd.valid = 1'b1;
    do
      @(negedge clk);
    while (!lsu_rsp.valid);
    last_lsu_data = lsu_rsp.data;
    lsu_seen      = 1'b1;
    step();
    lsu_rd.valid = 1'b0;
  endtask

  task automatic store(input bus_pkg::addr_t addr, input bus_pkg::word_t data,
                       input bus_pkg::strb4_t strb);
    int              pulses;
    int              count_before;
    int              off;
    int              lane_base;
    bus_pkg::dword_t exp_d;
    bus_pkg::strb8_t exp_s;
    step();
    off       = int'(addr[1:0]);
    lane_base = addr[2] ? 4 : 0;
    exp_d     = '0;
    exp_s     = '0;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
      begin
        exp_s[lane_base + off + i]              = 1'b1;
        exp_d[8*(lane_base + off + i) +: 8]     = data[8*i +: 8];
        exp_mem[addr[10:2]][8*(off + i) +: 8]   = data[8*i +: 8];
      end
    end
    exp_awaddr   = addr;
    exp_awsize   = size_of(strb);
    exp_wdata    = exp_d;
    exp_wstrb    = exp_s;
    count_before = slave_i.wr_count;
    pulses       = 0;
    lsu_wr.addr  = addr;
    lsu_wr.data  = data;
    lsu_wr.strb  = strb;
    lsu_wr.valid = 1'b1;
    do
    begin
      @(negedge clk);
      if (wdone)
        pulses++;
    end
    while (!wdone);
    step();
    lsu_wr.valid = 1'b0;
    repeat (3)
    begin
      @(negedge clk);
      if (wdone)
        pulses++;
    end
    assert (pulses == 1)
      else
      begin
        $display("%s: store to %h gave %0d wdone pulses", test_name, addr, pulses);
        err_count++;
      end
    assert (slave_i.wr_count == count_before + 1)
      else
      begin
        $display("%s: store to %h gave %0d writes in memory", test_name, addr,
                 slave_i.wr_count - count_before);
        err_count++;
      end
  endtask

  // store then read back the whole word
  task automatic store_load(input bus_pkg::addr_t addr, input bus_pkg::strb4_t strb);
    store(addr, rand_word(), strb);
    load({addr[31:2], 2'b00}, 4'hf, exp_mem[addr[10:2]]);
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count != test_err_base)
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, err_count - test_err_base);
    end
    else
      $display("test %s: passed", test_name);
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a reply never arrived", cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    bus_pkg::addr_t  a;
    logic [31:0]     r;
    rst           = 1'b1;
    ifu_req       = '0;
    lsu_rd        = '0;
    lsu_wr        = '0;
    lsu_chk       = 1'b1;
    clint_inc_chk = 1'b0;
    clint_mode    = 1'b0;
    order_mode    = 1'b0;
    lsu_seen      = 1'b0;
    prev_clint    = '0;
    err_count     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    rng_state     = 32'd55849;
    test_name     = "reset";
    for (int i = 0; i < 512; i++)
      exp_mem[i] = word_fill(bus_pkg::addr_t'(i * 4));
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("clint_hi");
    clint_mode = 1'b1;
    load(bus_pkg::CLINT_ADDR_HI, 4'hf, 32'h0);
    clint_mode = 1'b0;
    end_test();

    begin_test("fetch_lo");
    fetch(32'h0000_0100);
    fetch(32'h0000_0238);
    end_test();

    begin_test("fetch_hi");
    fetch(32'h0000_0104);
    fetch(32'h0000_03fc);
    end_test();

    begin_test("lsu_first");
    order_mode = 1'b1;
    lsu_seen   = 1'b0;
    fork
      fetch(32'h0000_0208);
      load(32'h0000_020c, 4'hf, exp_mem[9'h083]);
    join
    order_mode = 1'b0;
    end_test();

    begin_test("store_byte");
    for (int lane = 0; lane < 2; lane++)
      for (int off = 0; off < 4; off++)
        store_load(bus_pkg::addr_t'(32'h300 + lane * 4 + off), 4'h1);
    end_test();

    begin_test("store_half");
    for (int lane = 0; lane < 2; lane++)
      for (int off = 0; off < 3; off++)
        store_load(bus_pkg::addr_t'(32'h340 + lane * 4 + off), 4'h3);
    end_test();

    begin_test("store_word");
    store_load(32'h0000_0380, 4'hf);
    store_load(32'h0000_0384, 4'hf);
    end_test();

    begin_test("store_random");
    repeat (10)
    begin
      r = rand_word();
      a = {21'h0, 1'b1, r[9:2], 2'b00}; // word in 0x400 to 0x7fc
      case (r[12:11])
        2'd0:    store_load(a + bus_pkg::addr_t'(r[14:13]), 4'h1);
        2'd1:    store_load(a + (r[13] ? 32'd2 : 32'd0), 4'h3);
        default: store_load(a, 4'hf);
      endcase
    end
    end_test();

    begin_test("clint_inc");
    clint_mode    = 1'b1;
    lsu_chk       = 1'b0;
    clint_inc_chk = 1'b1;
    repeat (3)
    begin
      load(bus_pkg::CLINT_ADDR_LO, 4'hf, 32'h0);
      prev_clint = last_lsu_data;
      step();
    end
    clint_inc_chk = 1'b0;
    lsu_chk       = 1'b1;
    clint_mode    = 1'b0;
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/bus_pkg.sv
hdl/bus_req_decode.sv
hdl/bus_arbiter.sv
hdl/bus_resp_route.sv
hdl/bus_clint.sv
hdl/bus_top.sv
tb/axi_slave_model.sv
tb/tb_bus_top.sv

/* Makefile */
TOP := tb_bus_top

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -j 0

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
